// ==== compile.f ====
hw/apb_subsys_pkg.sv
hw/ahb_endian_swap.sv
hw/ahb_to_apb_bridge.sv
hw/apb_slot_mux.sv
hw/apb_gpio.sv
hw/apb_sram.sv
hw/apb_subsystem.sv
test/tb_apb_subsystem.sv

// ==== hw/ahb_endian_swap.sv ====
// Swap control is held from one accept to the next, so only one transfer may be in flight
`timescale 1ns/1ps

module ahb_endian_swap (
  input  logic                              HCLK,
  input  logic                              HRESETn,
  input  logic                              i_xfer_accept,
  input  logic [2:0]                        i_hsize,
  input  logic                              i_big_endian,
  input  logic [apb_subsys_pkg::DATA_W-1:0] i_hwdata_ahb,
  input  logic [apb_subsys_pkg::DATA_W-1:0] i_hrdata_le,
  output logic [apb_subsys_pkg::DATA_W-1:0] o_hwdata_le,
  output logic [apb_subsys_pkg::DATA_W-1:0] o_hrdata_ahb
);
  import apb_subsys_pkg::*;

  // Bit 0 swaps bytes in each halfword, bit 1 swaps the halfwords
  logic [1:0] swap_ctrl;
  logic [1:0] swap_ctrl_nxt;

  // Byte swap first, then halfword swap
  function automatic logic [DATA_W-1:0] swap_bytes(input logic [DATA_W-1:0] din,
                                                   input logic [1:0]        ctrl);
    logic [DATA_W-1:0] stage;
    stage = ctrl[0] ? {din[23:16], din[31:24], din[7:0], din[15:8]} : din;
    return ctrl[1] ? {stage[15:0], stage[31:16]} : stage;
  endfunction

  // Byte access or little endian needs no swap
  always_comb
  begin
    swap_ctrl_nxt = 2'b00;
    if (i_big_endian)
    begin
      swap_ctrl_nxt[0] = (i_hsize == HSIZE_HALF) || (i_hsize == HSIZE_WORD);
      swap_ctrl_nxt[1] = (i_hsize == HSIZE_WORD);
    end
  end

  // Captured in the address phase for the data phase
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      swap_ctrl <= 2'b00;
    end
    else if (i_xfer_accept)
    begin
      swap_ctrl <= swap_ctrl_nxt;
    end
  end

  // Same swap both ways
  assign o_hwdata_le  = swap_bytes(i_hwdata_ahb, swap_ctrl);
  assign o_hrdata_ahb = swap_bytes(i_hrdata_le, swap_ctrl);

endmodule

// ==== hw/ahb_to_apb_bridge.sv ====
// i_hwdata must stay stable through the data phase since write data is not registered
`timescale 1ns/1ps

module ahb_to_apb_bridge (
  input  logic                                  HCLK,
  input  logic                                  HRESETn,
  input  logic                                  i_hsel,
  input  logic [apb_subsys_pkg::AHB_ADDR_W-1:0] i_haddr,
  input  logic [1:0]                            i_htrans,
  input  logic                                  i_hwrite,
  input  logic                                  i_hready,
  input  logic [apb_subsys_pkg::DATA_W-1:0]     i_hwdata,
  input  logic                                  i_pready,
  input  logic [apb_subsys_pkg::DATA_W-1:0]     i_prdata,
  output logic                                  o_xfer_accept,
  output logic                                  o_hreadyout,
  output logic [apb_subsys_pkg::DATA_W-1:0]     o_hrdata,
  output logic                                  o_apbactive,
  output logic [apb_subsys_pkg::AHB_ADDR_W-1:0] o_paddr,
  output logic                                  o_psel,
  output logic                                  o_penable,
  output logic                                  o_pwrite,
  output logic [apb_subsys_pkg::DATA_W-1:0]     o_pwdata
);
  import apb_subsys_pkg::*;

  bridge_state_t         state;
  bridge_state_t         state_nxt;
  logic                  xfer_accept;
  logic [AHB_ADDR_W-1:0] addr_q;
  logic                  write_q;
  logic [DATA_W-1:0]     rdata_q;

  // Active transfer seen with bus ready
  assign xfer_accept = i_hsel & i_htrans[HTRANS_NONSEQ_BIT] & i_hready;

  // ------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:
      begin
        if (xfer_accept)
        begin
          state_nxt = SETUP;
        end
      end
      SETUP:   state_nxt = ACCESS;
      // Slave wait states hold us here
      ACCESS:
      begin
        if (i_pready)
        begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state   <= IDLE;
      write_q <= 1'b0;
      rdata_q <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (xfer_accept)
      begin
        write_q <= i_hwrite;
      end
      // Read data registered at end of access
      if ((state == ACCESS) && i_pready)
      begin
        rdata_q <= i_prdata;
      end
    end
  end

  // Address held for both APB phases
  always_ff @(posedge HCLK)
  begin
    if (xfer_accept)
    begin
      addr_q <= i_haddr;
    end
  end

  // ------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------
  assign o_xfer_accept = xfer_accept;
  assign o_hreadyout   = (state == IDLE);
  assign o_apbactive   = (state != IDLE);
  assign o_psel        = (state != IDLE);
  assign o_penable     = (state == ACCESS);
  assign o_paddr       = addr_q;
  assign o_pwrite      = write_q;
  // Write data straight from AHB
  assign o_pwdata      = i_hwdata;
  assign o_hrdata      = rdata_q;

endmodule

// ==== hw/apb_gpio.sv ====
// Word accesses only since there is no PSTRB, and the ID word ignores writes
`timescale 1ns/1ps

module apb_gpio (
  input  logic                              HCLK,
  input  logic                              HRESETn,
  input  logic                              i_psel,
  input  logic                              i_penable,
  input  logic                              i_pwrite,
  input  logic [11:0]                       i_paddr,
  input  logic [apb_subsys_pkg::DATA_W-1:0] i_pwdata,
  output logic [apb_subsys_pkg::DATA_W-1:0] o_prdata,
  output logic                              o_pready,
  output logic [apb_subsys_pkg::DATA_W-1:0] o_gpio_out
);
  import apb_subsys_pkg::*;

  logic              out_wr;
  logic [DATA_W-1:0] gpio_q;

  // Write lands on the ACCESS edge
  assign out_wr = i_psel & i_penable & i_pwrite & (i_paddr[11:2] == GPIO_OUT_OFS[11:2]);

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      gpio_q <= '0;
    end
    else if (out_wr)
    begin
      gpio_q <= i_pwdata;
    end
  end

  // Read decode by word offset
  always_comb
  begin
    o_prdata = '0;
    if (i_paddr[11:2] == GPIO_OUT_OFS[11:2])
    begin
      o_prdata = gpio_q;
    end
    else if (i_paddr[11:2] == GPIO_ID_OFS[11:2])
    begin
      o_prdata = GPIO_ID;
    end
  end

  // Zero wait
  assign o_pready   = 1'b1;
  assign o_gpio_out = gpio_q;

endmodule

// ==== hw/apb_slot_mux.sv ====
// Only slot 0 and slots 8 to 11 are populated, every other slot reads zero and never waits
`timescale 1ns/1ps

module apb_slot_mux (
  input  logic [apb_subsys_pkg::AHB_ADDR_W-1:0] i_paddr,
  input  logic                                  i_psel,
  input  logic                                  i_gpio_pready,
  input  logic [apb_subsys_pkg::DATA_W-1:0]     i_gpio_prdata,
  input  logic                                  i_mem_pready,
  input  logic [apb_subsys_pkg::DATA_W-1:0]     i_mem_prdata,
  output logic                                  o_gpio_psel,
  output logic                                  o_mem_psel,
  output logic                                  o_pready,
  output logic [apb_subsys_pkg::DATA_W-1:0]     o_prdata
);
  import apb_subsys_pkg::*;

  logic [SLOT_W-1:0]    slot;
  logic [NUM_SLOTS-1:0] slot_hit;
  logic                 gpio_hit;
  logic                 mem_hit;

  // Top address nibble picks the slot
  assign slot     = i_paddr[AHB_ADDR_W-1 -: SLOT_W];
  assign slot_hit = NUM_SLOTS'(1) << slot;
  assign gpio_hit = slot_hit[SLOT_GPIO];
  // Four aliased memory slots
  assign mem_hit  = |slot_hit[SLOT_MEM_LAST:SLOT_MEM_FIRST];

  assign o_gpio_psel = i_psel & gpio_hit;
  assign o_mem_psel  = i_psel & mem_hit;

  // Response select
  always_comb
  begin
    o_pready = 1'b1;
    o_prdata = '0;
    if (gpio_hit)
    begin
      o_pready = i_gpio_pready;
      o_prdata = i_gpio_prdata;
    end
    else if (mem_hit)
    begin
      o_pready = i_mem_pready;
      o_prdata = i_mem_prdata;
    end
  end

endmodule

// ==== hw/apb_sram.sv ====
// Only address bits 7 to 2 index the array, so contents alias every 256 bytes and start unknown
`timescale 1ns/1ps

module apb_sram (
  input  logic                              HCLK,
  input  logic                              i_psel,
  input  logic                              i_penable,
  input  logic                              i_pwrite,
  input  logic [13:0]                       i_paddr,
  input  logic [apb_subsys_pkg::DATA_W-1:0] i_pwdata,
  output logic [apb_subsys_pkg::DATA_W-1:0] o_prdata,
  output logic                              o_pready
);
  import apb_subsys_pkg::*;

  logic [DATA_W-1:0]    mem [MEM_WORDS];
  logic [MEM_IDX_W-1:0] idx;
  logic                 mem_wr;

  // Word index, upper bits wrap
  assign idx    = i_paddr[MEM_IDX_W+1:2];
  assign mem_wr = i_psel & i_penable & i_pwrite;

  // ------------------------------------------------------------
  // Register file
  // ------------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (mem_wr)
    begin
      mem[idx] <= i_pwdata;
    end
  end

  // Combinational read
  assign o_prdata = mem[idx];
  // Never waits
  assign o_pready = 1'b1;

endmodule

// ==== hw/apb_subsys_pkg.sv ====
// Shared sizes and slot map for the single clock APB subsystem, which has no strobes and no errors
package apb_subsys_pkg;

  // ------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------
  localparam int AHB_ADDR_W = 16;
  localparam int DATA_W     = 32;

  // Slot index from address bits 15 to 12
  localparam int SLOT_W         = 4;
  localparam int NUM_SLOTS      = 16;
  localparam int SLOT_GPIO      = 0;
  // Memory answers in four aliased slots
  localparam int SLOT_MEM_FIRST = 8;
  localparam int SLOT_MEM_LAST  = 11;

  // ------------------------------------------------------------
  // GPIO register map
  // ------------------------------------------------------------
  localparam logic [11:0]       GPIO_OUT_OFS = 12'h000;
  localparam logic [11:0]       GPIO_ID_OFS  = 12'h004;
  localparam logic [DATA_W-1:0] GPIO_ID      = 32'h00FA50C0;

  // Scratch memory, word index from address bits 7 to 2
  localparam int MEM_WORDS = 64;
  localparam int MEM_IDX_W = 6;

  // AHB encodings
  localparam int         HTRANS_NONSEQ_BIT = 1;
  localparam logic [2:0] HSIZE_HALF        = 3'd1;
  localparam logic [2:0] HSIZE_WORD        = 3'd2;

  // Bridge FSM states
  typedef enum logic [1:0] {IDLE, SETUP, ACCESS} bridge_state_t;

endpackage

// ==== hw/apb_subsystem.sv ====
// APB runs on HCLK, one transfer at a time, and i_big_endian should only change between transfers
`timescale 1ns/1ps

module apb_subsystem (
  input  logic                                  HCLK,
  input  logic                                  HRESETn,
  input  logic                                  i_hsel,
  input  logic [apb_subsys_pkg::AHB_ADDR_W-1:0] i_haddr,
  input  logic [1:0]                            i_htrans,
  input  logic                                  i_hwrite,
  input  logic [2:0]                            i_hsize,
  input  logic                                  i_hready,
  input  logic [apb_subsys_pkg::DATA_W-1:0]     i_hwdata,
  input  logic                                  i_big_endian,
  output logic                                  o_hreadyout,
  output logic [apb_subsys_pkg::DATA_W-1:0]     o_hrdata,
  output logic                                  o_apbactive,
  output logic [apb_subsys_pkg::DATA_W-1:0]     o_gpio_out
);
  import apb_subsys_pkg::*;

  // ------------------------------------------------------------
  // Internal wires
  // ------------------------------------------------------------
  logic                  xfer_accept;
  logic [DATA_W-1:0]     hwdata_le;
  logic [DATA_W-1:0]     hrdata_le;
  // Shared APB bus
  logic [AHB_ADDR_W-1:0] paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [DATA_W-1:0]     pwdata;
  logic                  pready;
  logic [DATA_W-1:0]     prdata;
  // Per slave
  logic                  gpio_psel;
  logic                  gpio_pready;
  logic [DATA_W-1:0]     gpio_prdata;
  logic                  mem_psel;
  logic                  mem_pready;
  logic [DATA_W-1:0]     mem_prdata;

  ahb_endian_swap u_endian_swap (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .i_xfer_accept (xfer_accept),
    .i_hsize       (i_hsize),
    .i_big_endian  (i_big_endian),
    .i_hwdata_ahb  (i_hwdata),
    .i_hrdata_le   (hrdata_le),
    .o_hwdata_le   (hwdata_le),
    .o_hrdata_ahb  (o_hrdata)
  );

  ahb_to_apb_bridge u_bridge (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .i_hsel        (i_hsel),
    .i_haddr       (i_haddr),
    .i_htrans      (i_htrans),
    .i_hwrite      (i_hwrite),
    .i_hready      (i_hready),
    .i_hwdata      (hwdata_le),
    .i_pready      (pready),
    .i_prdata      (prdata),
    .o_xfer_accept (xfer_accept),
    .o_hreadyout   (o_hreadyout),
    .o_hrdata      (hrdata_le),
    .o_apbactive   (o_apbactive),
    .o_paddr       (paddr),
    .o_psel        (psel),
    .o_penable     (penable),
    .o_pwrite      (pwrite),
    .o_pwdata      (pwdata)
  );

  // Slot decode and response mux
  apb_slot_mux u_slot_mux (
    .i_paddr       (paddr),
    .i_psel        (psel),
    .i_gpio_pready (gpio_pready),
    .i_gpio_prdata (gpio_prdata),
    .i_mem_pready  (mem_pready),
    .i_mem_prdata  (mem_prdata),
    .o_gpio_psel   (gpio_psel),
    .o_mem_psel    (mem_psel),
    .o_pready      (pready),
    .o_prdata      (prdata)
  );

  // Slot 0
  apb_gpio u_gpio (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .i_psel     (gpio_psel),
    .i_penable  (penable),
    .i_pwrite   (pwrite),
    .i_paddr    (paddr[11:0]),
    .i_pwdata   (pwdata),
    .o_prdata   (gpio_prdata),
    .o_pready   (gpio_pready),
    .o_gpio_out (o_gpio_out)
  );

  // Slots 8 to 11
  apb_sram u_sram (
    .HCLK      (HCLK),
    .i_psel    (mem_psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr[13:0]),
    .i_pwdata  (pwdata),
    .o_prdata  (mem_prdata),
    .o_pready  (mem_pready)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_apb_subsystem \
  -f compile.f \
  -o tb_sim

out="$(./obj_dir/tb_sim)"
echo "$out"
echo "$out" | grep -qx "TB PASSED"

// ==== test/tb_apb_subsystem.sv ====
// Word and halfword AHB transfers only, one in flight, memory reads only of indices already written
`timescale 1ns/1ps

module tb_apb_subsystem;
  import apb_subsys_pkg::*;

  localparam int NUM_XFERS   = 49;
  localparam int CYCLE_LIMIT = 4 * NUM_XFERS + 200;

  logic        HCLK;
  logic        HRESETn;
  logic        i_hsel;
  logic [15:0] i_haddr;
  logic [1:0]  i_htrans;
  logic        i_hwrite;
  logic [2:0]  i_hsize;
  logic        i_hready;
  logic [31:0] i_hwdata;
  logic        i_big_endian;
  logic        o_hreadyout;
  logic [31:0] o_hrdata;
  logic        o_apbactive;
  logic [31:0] o_gpio_out;

  // Reference state
  logic [31:0] gpio_shadow;
  logic [31:0] mem_shadow [64];
  // Pending read results for the compare process
  logic [31:0] exp_q [$];
  logic [31:0] act_q [$];
  string       lbl_q [$];
  time         tim_q [$];
  logic [31:0] cmp_exp;
  logic [31:0] cmp_act;
  string       cmp_lbl;
  time         cmp_tim;

  int pass_cnt;
  int fail_cnt;
  int timing_fail;
  int xfer_cnt;
  int cycle_cnt;
  int test_num;

  apb_subsystem apb_subsystem_i (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_hsel       (i_hsel),
    .i_haddr      (i_haddr),
    .i_htrans     (i_htrans),
    .i_hwrite     (i_hwrite),
    .i_hsize      (i_hsize),
    .i_hready     (i_hready),
    .i_hwdata     (i_hwdata),
    .i_big_endian (i_big_endian),
    .o_hreadyout  (o_hreadyout),
    .o_hrdata     (o_hrdata),
    .o_apbactive  (o_apbactive),
    .o_gpio_out   (o_gpio_out)
  );

  // 8 ns clock
  initial
  begin
    HCLK = 1'b0;
    forever #4 HCLK = ~HCLK;
  end

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  // Big endian word reverses all four byte lanes
  // Big endian halfword exchanges the two bytes of each half
  function automatic logic [31:0] apply_bus_order(input logic [31:0] w, input logic [2:0] size,
                                                  input logic big);
    logic [31:0] res;
    int          lane_flip;
    lane_flip = 0;
    if (big && (size == HSIZE_WORD))
    begin
      lane_flip = 3;
    end
    else if (big && (size == HSIZE_HALF))
    begin
      lane_flip = 1;
    end
    // Lane b takes the byte from lane b xor flip
    for (int b = 0; b < 4; b++)
    begin
      res[8*b +: 8] = w[8*(b ^ lane_flip) +: 8];
    end
    return res;
  endfunction

  // Expected AHB read word for an address
  function automatic logic [31:0] expected_read(input logic [15:0] addr, input logic [2:0] size,
                                                input logic big);
    logic [31:0] word;
    word = 32'h0;
    // GPIO in slot 0 and memory in slots 8 to 11
    if (addr[15:12] == 4'h0)
    begin
      if (addr[11:2] == 10'd0)
      begin
        word = gpio_shadow;
      end
      else if (addr[11:2] == 10'd1)
      begin
        word = GPIO_ID;
      end
    end
    else if (addr[15:14] == 2'b10)
    begin
      word = mem_shadow[addr[7:2]];
    end
    return apply_bus_order(word, size, big);
  endfunction

  task automatic model_write(input logic [15:0] addr, input logic [2:0] size, input logic big,
                             input logic [31:0] wdata);
    logic [31:0] stored;
    stored = apply_bus_order(wdata, size, big);
    if ((addr[15:12] == 4'h0) && (addr[11:2] == 10'd0))
    begin
      gpio_shadow = stored;
    end
    else if (addr[15:14] == 2'b10)
    begin
      mem_shadow[addr[7:2]] = stored;
    end
  endtask

  // ------------------------------------------------------------
  // AHB driver
  // ------------------------------------------------------------
  task automatic bus_xfer(input logic wr, input logic [15:0] addr, input logic [2:0] size,
                          input logic big, input logic [31:0] wdata, output logic [31:0] rdata);
    int   low_cnt;
    logic act_ok;
    // Address phase
    @(posedge HCLK);
    i_hsel       <= 1'b1;
    i_haddr      <= addr;
    i_htrans     <= 2'b10;
    i_hwrite     <= wr;
    i_hsize      <= size;
    i_big_endian <= big;
    // Data phase starts on the accept edge
    @(posedge HCLK);
    i_hsel   <= 1'b0;
    i_htrans <= 2'b00;
    i_hwdata <= wdata;
    low_cnt = 0;
    act_ok  = 1'b1;
    @(negedge HCLK);
    while (!o_hreadyout)
    begin
      low_cnt++;
      if (!o_apbactive)
      begin
        act_ok = 1'b0;
      end
      @(negedge HCLK);
    end
    if (o_apbactive)
    begin
      act_ok = 1'b0;
    end
    xfer_cnt++;
    if (low_cnt != 2)
    begin
      $display("Fail at %0t: o_hreadyout low cycles exp=2 got=%0d", $time, low_cnt);
      fail_cnt++;
      timing_fail++;
    end
    else if (!act_ok)
    begin
      $display("Fail at %0t: o_apbactive did not match the waited cycles", $time);
      fail_cnt++;
      timing_fail++;
    end
    else
    begin
      pass_cnt++;
    end
    rdata = o_hrdata;
  endtask

  task automatic write_word(input logic [15:0] addr, input logic [2:0] size, input logic big,
                            input logic [31:0] wdata);
    logic [31:0] unused_rd;
    bus_xfer(1'b1, addr, size, big, wdata, unused_rd);
    model_write(addr, size, big, wdata);
  endtask

  // Queue the read for the compare process
  task automatic read_check(input string lbl, input logic [15:0] addr, input logic [2:0] size,
                            input logic big);
    logic [31:0] exp;
    logic [31:0] act;
    exp = expected_read(addr, size, big);
    bus_xfer(1'b0, addr, size, big, 32'h0, act);
    exp_q.push_back(exp);
    act_q.push_back(act);
    lbl_q.push_back(lbl);
    tim_q.push_back($time);
  endtask

  task automatic end_test(input string name, input int fails_before);
    // Let the compare process drain
    @(posedge HCLK);
    @(negedge HCLK);
    test_num++;
    if (fail_cnt == fails_before)
    begin
      $display("Test %0d %s: ok", test_num, name);
    end
    else
    begin
      $display("Test %0d %s: %0d failures", test_num, name, fail_cnt - fails_before);
    end
  endtask

  // ------------------------------------------------------------
  // Compare process
  // ------------------------------------------------------------
  always @(posedge HCLK)
  begin
    while (act_q.size() > 0)
    begin
      cmp_exp = exp_q.pop_front();
      cmp_act = act_q.pop_front();
      cmp_lbl = lbl_q.pop_front();
      cmp_tim = tim_q.pop_front();
      if (cmp_act !== cmp_exp)
      begin
        $display("Fail at %0t: o_hrdata (%s) exp=%h got=%h", cmp_tim, cmp_lbl, cmp_exp, cmp_act);
        fail_cnt++;
      end
      else
      begin
        pass_cnt++;
      end
    end
  end

  // Watchdog
  always @(posedge HCLK)
  begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("Run stopped after %0d cycles, a transfer never completed", cycle_cnt);
      $display("TB FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  initial
  begin
    logic [31:0] seed_ret;
    logic [31:0] val;
    logic [31:0] rnd;
    logic [5:0]  w_idx [20];
    logic [3:0]  w_slot [20];
    logic [1:0]  alias_ofs;
    int          fails0;
    seed_ret = $urandom(32'ha991_1c41);
    pass_cnt    = 0;
    fail_cnt    = 0;
    timing_fail = 0;
    xfer_cnt    = 0;
    cycle_cnt   = 0;
    test_num    = 0;
    gpio_shadow = 32'h0;
    HRESETn      <= 1'b0;
    i_hsel       <= 1'b0;
    i_haddr      <= 16'h0;
    i_htrans     <= 2'b00;
    i_hwrite     <= 1'b0;
    i_hsize      <= HSIZE_WORD;
    i_hready     <= 1'b1;
    i_hwdata     <= 32'h0;
    i_big_endian <= 1'b0;
    repeat (4) @(posedge HCLK);
    HRESETn <= 1'b1;
    @(negedge HCLK);

    // Reset values and ID word
    fails0 = fail_cnt;
    if (o_hreadyout !== 1'b1)
    begin
      $display("Fail at %0t: o_hreadyout exp=1 got=%b", $time, o_hreadyout);
      fail_cnt++;
    end
    if (o_apbactive !== 1'b0)
    begin
      $display("Fail at %0t: o_apbactive exp=0 got=%b", $time, o_apbactive);
      fail_cnt++;
    end
    if (o_gpio_out !== 32'h0)
    begin
      $display("Fail at %0t: o_gpio_out exp=00000000 got=%h", $time, o_gpio_out);
      fail_cnt++;
    end
    read_check("gpio id", 16'h0004, HSIZE_WORD, 1'b0);
    end_test("reset and ID", fails0);

    // GPIO output register
    fails0 = fail_cnt;
    val = $urandom;
    write_word(16'h0000, HSIZE_WORD, 1'b0, val);
    if (o_gpio_out !== val)
    begin
      $display("Fail at %0t: o_gpio_out exp=%h got=%h", $time, val, o_gpio_out);
      fail_cnt++;
    end
    read_check("gpio out", 16'h0000, HSIZE_WORD, 1'b0);
    end_test("GPIO write", fails0);

    // Memory through aliased slots 8 to 11
    fails0 = fail_cnt;
    for (int i = 0; i < 20; i++)
    begin
      rnd = $urandom;
      w_idx[i]  = rnd[5:0];
      w_slot[i] = {2'b10, rnd[7:6]};
      write_word({w_slot[i], rnd[11:8], w_idx[i], 2'b00}, HSIZE_WORD, 1'b0, $urandom);
    end
    for (int i = 0; i < 20; i++)
    begin
      rnd = $urandom;
      alias_ofs = (rnd[1:0] == 2'b00) ? 2'b01 : rnd[1:0];
      read_check("mem alias", {2'b10, w_slot[i][1:0] ^ alias_ofs, rnd[5:2], w_idx[i], 2'b00},
                 HSIZE_WORD, 1'b0);
    end
    end_test("memory aliases", fails0);

    // Empty slots
    fails0 = fail_cnt;
    read_check("slot 3", 16'h3004, HSIZE_WORD, 1'b0);
    read_check("slot 15", 16'hF010, HSIZE_WORD, 1'b0);
    end_test("unmapped slots", fails0);

    // Big endian word write followed by reads in both orders
    fails0 = fail_cnt;
    val = $urandom;
    write_word(16'h9028, HSIZE_WORD, 1'b1, val);
    read_check("le word", 16'hA028, HSIZE_WORD, 1'b0);
    read_check("be word", 16'hB028, HSIZE_WORD, 1'b1);
    read_check("be half", 16'h8028, HSIZE_HALF, 1'b1);
    end_test("big endian", fails0);

    // Timing was checked inside every transfer
    test_num++;
    if (timing_fail == 0)
    begin
      $display("Test %0d transfer timing: ok over %0d transfers", test_num, xfer_cnt);
    end
    else
    begin
      $display("Test %0d transfer timing: %0d failures", test_num, timing_fail);
    end

    $display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
